// File: source/icachePkg.sv
// Instruction-cache miss subsystem shared definitions
// Widths, FSM state and slot encodings, request structs

package icachePkg;

	// ====================
	// Fixed widths
	// ====================
	// Program counter width
	localparam int PcWidth = 32;
	// 32-byte lines
	localparam int LineOffsetBits = 5;
	localparam int AsidWidth = 8;
	// Line address, PC bits above the offset
	localparam int LineAddrWidth = PcWidth - LineOffsetBits;

	// ====================
	// Encodings
	// ====================
	// Miss controller states, in sequence order
	typedef enum logic [3:0] {
		stIdle,
		stIc2,
		stIc3,
		stIc3a,
		stWaitL2,
		stIc5,
		stIc6,
		stIc7,
		stIcNext
	} icState_e;

	// Fetch slot, lowest number has priority
	typedef enum logic [1:0] {
		slot0,
		slot1,
		slot2
	} slot_e;

	// ====================
	// Request structs
	// ====================
	// One fetch cycle, three slot PCs
	typedef struct packed {
		logic [AsidWidth-1:0] asid;
		logic [PcWidth-1:0] pc0;
		logic [PcWidth-1:0] pc1;
		logic [PcWidth-1:0] pc2;
		// Slots 1 and 2 use their own PCs
		logic threadEn;
	} fetchReq_t;

	// One cache line in one address space
	typedef struct packed {
		logic [AsidWidth-1:0] asid;
		logic [LineAddrWidth-1:0] lineAddr;
	} lineReq_t;

endpackage

// File: source/l1TagStore.sv
// Direct-mapped L1 instruction tag store
// Three combinational lookup ports, one install port, valid clear walk on reset

`timescale 1ns/1ps

module l1TagStore import icachePkg::*; #(
	parameter int L1Lines = 16
) (
	input logic clk,
	input logic rstN,
	input lineReq_t [2:0] lookupLines,
	output logic [2:0] hits,
	input logic l1Install,
	input lineReq_t pendLine
);

	// ====================
	// Geometry
	// ====================
	localparam int IdxBits = $clog2(L1Lines);
	// Stored tag holds asid plus line address above the index
	localparam int TagWidth = AsidWidth + LineAddrWidth - IdxBits;

	logic [TagWidth-1:0] tagMem [L1Lines];
	logic [L1Lines-1:0] validBits;
	// Clear walker steps once per reset cycle
	logic [IdxBits-1:0] clrIdx;

	// Low line address bits pick the entry
	function automatic logic [IdxBits-1:0] lineIdx(input lineReq_t line);
		return line.lineAddr[IdxBits-1:0];
	endfunction

	// Asid and upper line bits form the tag
	function automatic logic [TagWidth-1:0] lineTag(input lineReq_t line);
		return {line.asid, line.lineAddr[LineAddrWidth-1:IdxBits]};
	endfunction

	// ====================
	// Lookup
	// ====================
	// Each slot checks its own entry in the same cycle
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			hits[i] = validBits[lineIdx(lookupLines[i])] &&
				(tagMem[lineIdx(lookupLines[i])] == lineTag(lookupLines[i]));
		end
	end

	// ====================
	// Valid bits
	// ====================
	// Reset walks one entry per cycle
	// reset must last at least L1Lines cycles
	always_ff @(posedge clk) begin
		if (!rstN) begin
			validBits[clrIdx] <= 1'b0;
			clrIdx <= clrIdx + IdxBits'(1);
		end else if (l1Install) begin
			validBits[lineIdx(pendLine)] <= 1'b1;
		end
	end

	// Tag array is written on install only
	always_ff @(posedge clk) begin
		if (l1Install) begin
			tagMem[lineIdx(pendLine)] <= lineTag(pendLine);
		end
	end

endmodule

// File: source/l2TagStore.sv
// L2 instruction tag store, direct mapped
// Registered lookup of the pending miss line, install on bus fill

`timescale 1ns/1ps

module l2TagStore import icachePkg::*; #(
	parameter int L2Lines = 64
) (
	input logic clk,
	input logic rstN,
	input lineReq_t pendLine,
	input logic l2Install,
	output logic l2Hit
);

	// ====================
	// Geometry
	// ====================
	localparam int IdxBits = $clog2(L2Lines);
	localparam int TagWidth = AsidWidth + LineAddrWidth - IdxBits;

	logic [TagWidth-1:0] tagMem [L2Lines];
	logic [L2Lines-1:0] validBits;
	// Entry and tag of the pending line
	logic [IdxBits-1:0] pendIdx;
	logic [TagWidth-1:0] pendTag;

	assign pendIdx = pendLine.lineAddr[IdxBits-1:0];
	assign pendTag = {pendLine.asid, pendLine.lineAddr[LineAddrWidth-1:IdxBits]};

	// ====================
	// Lookup
	// ====================
	// Hit follows pendLine one cycle later
	// controller samples it in stWaitL2
	always_ff @(posedge clk) begin
		if (!rstN) begin
			l2Hit <= 1'b0;
		end else begin
			l2Hit <= validBits[pendIdx] && (tagMem[pendIdx] == pendTag);
		end
	end

	// ====================
	// Install
	// ====================
	// All valid bits drop together on reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			validBits <= '0;
		end else if (l2Install) begin
			validBits[pendIdx] <= 1'b1;
		end
	end

	// Bus fill writes the tag, later misses to this line hit here
	always_ff @(posedge clk) begin
		if (l2Install) begin
			tagMem[pendIdx] <= pendTag;
		end
	end

endmodule

// File: source/icMissController.sv
// Instruction-cache miss controller
// Picks the first missing slot, forms its line and steps the L2 or bus fill

`timescale 1ns/1ps

module icMissController import icachePkg::*; (
	input logic clk,
	input logic rstN,
	input fetchReq_t fetch,
	input logic [2:0] hits,
	input logic l2Hit,
	input logic busFillDone,
	output lineReq_t [2:0] lookupLines,
	output lineReq_t pendLine,
	output slot_e missSlot,
	output logic l1Install,
	output logic l2Install,
	output logic busReq,
	output logic icNext
);

	icState_e state;
	// Previous state, qualifies l2Hit on the first stWaitL2 cycle
	icState_e prevState;
	logic [PcWidth-1:0] pcPlus7;
	logic [PcWidth-1:0] pcPlus14;
	slot_e firstMiss;
	logic anyMiss;
	logic l2Ready;

	// Line of a PC in one address space
	function automatic lineReq_t toLine(input logic [AsidWidth-1:0] asid,
		input logic [PcWidth-1:0] pc);
		lineReq_t line;
		line.asid = asid;
		line.lineAddr = pc[PcWidth-1:LineOffsetBits];
		return line;
	endfunction

	// ====================
	// Slot lines
	// ====================
	// Single thread, slots 1 and 2 follow pc0
	assign pcPlus7 = fetch.pc0 + PcWidth'(7);
	assign pcPlus14 = fetch.pc0 + PcWidth'(14);

	always_comb begin
		lookupLines[0] = toLine(fetch.asid, fetch.pc0);
		lookupLines[1] = toLine(fetch.asid, fetch.threadEn ? fetch.pc1 : pcPlus7);
		lookupLines[2] = toLine(fetch.asid, fetch.threadEn ? fetch.pc2 : pcPlus14);
	end

	// Lowest numbered miss wins
	always_comb begin
		if (!hits[0]) begin
			firstMiss = slot0;
		end else if (!hits[1]) begin
			firstMiss = slot1;
		end else begin
			firstMiss = slot2;
		end
	end

	assign anyMiss = (hits != 3'b111);
	// L2 result only counts right after stIc3a
	assign l2Ready = l2Hit && (prevState == stIc3a);

	// ====================
	// Miss capture
	// ====================
	// Line and slot held for the whole miss
	always_ff @(posedge clk) begin
		if (state == stIdle && anyMiss) begin
			pendLine <= lookupLines[firstMiss];
			missSlot <= firstMiss;
		end
	end

	// ====================
	// State machine
	// ====================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stIdle;
			prevState <= stIdle;
			l1Install <= 1'b0;
			l2Install <= 1'b0;
			busReq <= 1'b0;
			icNext <= 1'b0;
		end else begin
			// Strobes last one cycle
			l1Install <= 1'b0;
			l2Install <= 1'b0;
			icNext <= 1'b0;
			prevState <= state;
			case (state)
				stIdle: begin
					if (anyMiss) begin
						state <= stIc2;
					end
				end
				stIc2: state <= stIc3;
				stIc3: state <= stIc3a;
				stIc3a: state <= stWaitL2;
				stWaitL2: begin
					if (l2Ready) begin
						// Line already in L2, no bus cycle
						l1Install <= 1'b1;
						state <= stIc5;
					end else if (busReq && busFillDone) begin
						// Fill landed, install in both levels
						busReq <= 1'b0;
						l1Install <= 1'b1;
						l2Install <= 1'b1;
						state <= stIc5;
					end else begin
						// Hold request until the fill pulse
						busReq <= 1'b1;
					end
				end
				stIc5: state <= stIc6;
				stIc6: state <= stIc7;
				stIc7: state <= stIcNext;
				stIcNext: begin
					icNext <= 1'b1;
					state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// File: source/icacheMissTop.sv
// Instruction-cache miss subsystem top level
// L1 and L2 tag stores around the miss controller

`timescale 1ns/1ps

module icacheMissTop import icachePkg::*; #(
	parameter int L1Lines = 16,
	parameter int L2Lines = 64
) (
	input logic clk,
	input logic rstN,
	input fetchReq_t fetch,
	input logic busFillDone,
	output logic [2:0] hits,
	output lineReq_t missLine,
	output slot_e missSlot,
	output logic busReq,
	output logic icNext
);

	// ====================
	// Internal nets
	// ====================
	// Slot lines from the controller to L1
	lineReq_t [2:0] lookupLines;
	logic l2Hit;
	logic l1Install;
	logic l2Install;

	// Controller, missLine doubles as the pending line to both stores
	icMissController icMissController_inst (
		.clk(clk),
		.rstN(rstN),
		.fetch(fetch),
		.hits(hits),
		.l2Hit(l2Hit),
		.busFillDone(busFillDone),
		.lookupLines(lookupLines),
		.pendLine(missLine),
		.missSlot(missSlot),
		.l1Install(l1Install),
		.l2Install(l2Install),
		.busReq(busReq),
		.icNext(icNext)
	);

	// L1 tags, three lookups
	l1TagStore #(
		.L1Lines(L1Lines)
	) l1TagStore_inst (
		.clk(clk),
		.rstN(rstN),
		.lookupLines(lookupLines),
		.hits(hits),
		.l1Install(l1Install),
		.pendLine(missLine)
	);

	// L2 tags, pending line only
	l2TagStore #(
		.L2Lines(L2Lines)
	) l2TagStore_inst (
		.clk(clk),
		.rstN(rstN),
		.pendLine(missLine),
		.l2Install(l2Install),
		.l2Hit(l2Hit)
	);

endmodule

// File: tests/icacheMissTb.sv
// Instruction-cache miss subsystem testbench
// Replays stim rows, serves bus fills, checks miss lines, slots and latencies

`timescale 1ns/1ps

module icacheMissTb import icachePkg::*; ();

	localparam int NumRows = 12;
	localparam int RowWords = 9;
	// Worst case per miss, at most three misses per row
	localparam int CycleLimit = NumRows * 3 * (9 + 8 + 5) + 200;

	logic clk;
	logic rstN;
	fetchReq_t fetch;
	logic busFillDone;
	logic [2:0] hits;
	lineReq_t missLine;
	slot_e missSlot;
	logic busReq;
	logic icNext;

	// Row words: id asid pc0 pc1 pc2 threadEn expSlot expL2 expMask
	logic [31:0] stim [NumRows*RowWords];
	int errors;
	int cycles;
	int passCount;
	int failCount;

	icacheMissTop #(
		.L1Lines(16),
		.L2Lines(64)
	) icacheMissTop_inst (
		.clk(clk),
		.rstN(rstN),
		.fetch(fetch),
		.busFillDone(busFillDone),
		.hits(hits),
		.missLine(missLine),
		.missSlot(missSlot),
		.busReq(busReq),
		.icNext(icNext)
	);

	// ====================
	// Clock and run limit
	// ====================
	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CycleLimit) begin
			$display("Run stopped, no miss finished within %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// ====================
	// Helpers
	// ====================
	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// Expected line of a slot, slots 1 and 2 step 7 bytes off pc0 in single thread
	function automatic lineReq_t lineFor(input int r, input int slot);
		logic [31:0] pc;
		lineReq_t line;
		int b;
		b = r * RowWords;
		if (stim[b+5][0]) begin
			pc = stim[b+2+slot];
		end else begin
			pc = stim[b+2] + 32'(7 * slot);
		end
		line.asid = stim[b+1][7:0];
		line.lineAddr = pc[31:5];
		return line;
	endfunction

	task automatic driveRow(input int r);
		fetchReq_t req;
		int b;
		b = r * RowWords;
		req.asid = stim[b+1][7:0];
		req.pc0 = stim[b+2];
		req.pc1 = stim[b+3];
		req.pc2 = stim[b+4];
		req.threadEn = stim[b+5][0];
		fetch <= req;
	endtask

	// Follows one miss up to icNext, edges counted from the edge that presented it
	task automatic serveMiss(output int edges, output bit busSeen, output int pulseEdge);
		int fillWait;
		edges = 0;
		busSeen = 1'b0;
		pulseEdge = 0;
		fillWait = 0;
		do begin
			@(posedge clk);
			edges++;
			busFillDone <= (fillWait == 1);
			if (fillWait == 1) begin
				pulseEdge = edges;
			end
			if (fillWait > 0) begin
				fillWait--;
			end
			@(negedge clk);
			if (busReq && !busSeen) begin
				busSeen = 1'b1;
				// Bus answers 1 to 8 cycles later
				fillWait = int'($urandom_range(8, 1));
			end
		end while (!icNext);
	endtask

	// One fetch scenario, misses served until every slot hits
	task automatic runRow(input int r);
		int b;
		int misses;
		int edges;
		int pulseEdge;
		int startErrors;
		bit busSeen;
		logic [1:0] prevSlot;
		string tag;
		b = r * RowWords;
		misses = 0;
		startErrors = errors;
		prevSlot = 2'd0;
		while (hits != 3'b111 && misses < 3) begin
			serveMiss(edges, busSeen, pulseEdge);
			tag = $sformatf("t%0d miss%0d", stim[b], misses);
			if (misses == 0) begin
				checkValue({tag, " missSlot"}, {32'd0, stim[b+6]}, {62'd0, missSlot});
				checkValue({tag, " l2Path"}, {32'd0, stim[b+7]}, {63'd0, !busSeen});
			end else begin
				// Later misses move up in slot order
				checkValue({tag, " slotOrder"}, 64'd1, {63'd0, missSlot > prevSlot});
			end
			checkValue({tag, " missLine"}, {29'd0, lineFor(r, int'(missSlot))},
				{29'd0, missLine});
			if (busSeen) begin
				checkValue({tag, " fillToNext"}, 64'd5, 64'(edges - pulseEdge));
			end else begin
				checkValue({tag, " l2Latency"}, 64'd9, 64'(edges));
			end
			prevSlot = missSlot;
			misses++;
		end
		tag = $sformatf("t%0d", stim[b]);
		// Slot code 3 marks a row that should hit everywhere
		checkValue({tag, " anyMiss"}, {63'd0, stim[b+6] != 32'd3}, {63'd0, misses != 0});
		checkValue({tag, " hits"}, {32'd0, stim[b+8]}, {61'd0, hits});
		if (errors == startErrors) begin
			passCount++;
			$display("test %0d ok, %0d misses", stim[b], misses);
		end else begin
			failCount++;
			$display("test %0d FAILED, %0d misses", stim[b], misses);
		end
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		rstN = 1'b0;
		fetch = '0;
		busFillDone = 1'b0;
		errors = 0;
		cycles = 0;
		passCount = 0;
		failCount = 0;
		void'($urandom(32'hdb82));
		$readmemh("tests/icacheStim.txt", stim);
		// 16 reset edges, first row presented on release
		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		driveRow(0);
		@(negedge clk);
		checkValue("reset busReq", 64'd0, {63'd0, busReq});
		checkValue("reset icNext", 64'd0, {63'd0, icNext});
		checkValue("reset hits", 64'd0, {61'd0, hits});
		runRow(0);
		for (int r = 1; r < NumRows; r++) begin
			@(posedge clk);
			driveRow(r);
			@(negedge clk);
			runRow(r);
		end
		$display("%0d tests, %0d ok, %0d failing, %0d check errors",
			NumRows, passCount, failCount, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: tests/icacheStim.txt
// Columns: id asid pc0 pc1 pc2 threadEn expSlot expL2Hit expHitMask
// expSlot 3 means every slot already hits, pc1 and pc2 unused when threadEn is 0
// Cold miss, all three slots in one line
01 11 00001000 00001004 00001008 1 0 0 7
// Slot priority, slot 0 hits, slots 1 and 2 miss
02 11 00001000 00002020 00003040 1 1 0 7
// All three slots miss, served in order
03 11 00004060 000050a0 000060c0 1 0 0 7
// Single thread, slot 2 crosses into the next line
04 11 000080f8 deadbee0 deadbfe0 0 0 0 7
// Single thread, slots 1 and 2 share the next line
05 11 0000913c deadbee0 deadbfe0 0 0 0 7
// Index conflict evicts line 0x80 from L1
06 11 00001200 00001204 00001208 1 0 0 7
// Evicted line comes back from L2
07 11 00001000 00001004 00001008 1 0 1 7
// Same PC, new asid, misses both levels
08 22 00001000 00001004 00001008 1 0 0 7
// Every slot still resident
09 11 00004060 000050a0 000060c0 1 3 0 7
// L2 refill of line 0x90 under asid 11
0a 11 00001208 00002020 00003040 1 0 1 7
// L2 hit on slot 0, bus fill on slot 1
0b 22 00001000 0000a140 0000a144 1 0 1 7
// Single thread, slot 1 misses first
0c 11 0000811a 00000000 00000000 0 1 0 7

// File: src.f
source/icachePkg.sv
source/l1TagStore.sv
source/l2TagStore.sv
source/icMissController.sv
source/icacheMissTop.sv
tests/icacheMissTb.sv

// File: run.sh
#!/bin/bash
# Build and run the icache miss testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f src.f --top-module icacheMissTb -o icacheSim \
	&& ./obj_dir/icacheSim | tee sim.log \
	&& grep -qx "Test passed" sim.log \
	|| { echo "Simulation did not pass"; exit 1; }
echo "Simulation passed"
